// ==== pkt_pkg.sv ====
package pkt_pkg;

    // packet path widths
    localparam int BEAT_W = 256;
    localparam int KEY_W  = 512;

    // one bus beat of packet data
    typedef logic [BEAT_W-1:0] beat_t;

    // lookup key toward the match engine
    typedef logic [KEY_W-1:0] key_t;

    // rule index from the match engine
    typedef logic [15:0] rule_id_t;

    // table tag, top 16 bits of the key
    typedef logic [15:0] key_tag_t;

endpackage

// ==== cfg_pkg.sv ====
package cfg_pkg;

    // local bus data and address
    typedef logic [31:0] cfg_data_t;
    typedef logic [31:0] cfg_addr_t;

    // region code, address bits 15:13
    typedef logic [2:0] region_t;

    localparam region_t REGION_PARSER = 3'd3;
    localparam region_t REGION_ACTION = 3'd4;
    localparam region_t REGION_OUTPUT = 3'd5;

    // dispatcher FSM
    typedef enum logic [1:0] {
        IDLE_S,
        PARSE_S,
        WAIT_ACK_S,
        RELEASE_S
    } cfg_state_t;

endpackage

// ==== cfg_dispatch.sv ====
`timescale 1ns/100ps

module cfg_dispatch import cfg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    // host local bus
    input  logic      ctrl2um_cs_n,
    input  logic      ctrl_cmd,
    input  cfg_addr_t ctrl_addr,
    input  cfg_data_t ctrl_datain,
    output logic      um2ctrl_ack_n,
    output cfg_data_t ctrl_dataout,
    // shared toward the regions
    output logic      cfg_rw,
    output cfg_addr_t cfg_addr,
    output cfg_data_t cfg_wdata,
    output logic      parser_cs,
    input  logic      parser_ack,
    input  cfg_data_t parser_rdata,
    output logic      action_cs,
    input  logic      action_ack,
    input  cfg_data_t action_rdata,
    output logic      output_cs,
    input  logic      output_ack,
    input  cfg_data_t output_rdata
);

    logic [1:0] cs_sync;
    logic       cfg_valid;
    logic       mapped;
    region_t    region;
    cfg_state_t state;

    // cs_n comes from another clock domain, two flops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs_sync <= 2'b00;
        end else begin
            cs_sync <= {cs_sync[0], ~ctrl2um_cs_n};
        end
    end

    assign cfg_valid = cs_sync[1];

    // decode from the latched address
    assign region = cfg_addr[15:13];
    assign mapped = (region == REGION_PARSER) || (region == REGION_ACTION) ||
                    (region == REGION_OUTPUT);

    // host is holding the command stable, latch it once in idle
    always_ff @(posedge clk) begin
        if (state == IDLE_S && cfg_valid) begin
            cfg_rw    <= ctrl_cmd;
            cfg_addr  <= ctrl_addr;
            cfg_wdata <= ctrl_datain;
        end
    end

    // ********************************************************************
    // dispatch FSM
    // ********************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE_S;
            um2ctrl_ack_n <= 1'b1;
            ctrl_dataout  <= '0;
            parser_cs     <= 1'b0;
            action_cs     <= 1'b0;
            output_cs     <= 1'b0;
        end else begin
            case (state)
                IDLE_S: begin
                    um2ctrl_ack_n <= 1'b1;
                    if (cfg_valid) begin
                        state <= PARSE_S;
                    end
                end
                PARSE_S: begin
                    parser_cs <= (region == REGION_PARSER);
                    action_cs <= (region == REGION_ACTION);
                    output_cs <= (region == REGION_OUTPUT);
                    if (mapped) begin
                        state <= WAIT_ACK_S;
                    end else begin
                        // nobody home, answer with zero
                        ctrl_dataout <= '0;
                        state        <= RELEASE_S;
                    end
                end
                WAIT_ACK_S: begin
                    // only one select is up, pick its read data
                    if (parser_ack || action_ack || output_ack) begin
                        parser_cs <= 1'b0;
                        action_cs <= 1'b0;
                        output_cs <= 1'b0;
                        ctrl_dataout <= parser_cs ? parser_rdata :
                                        action_cs ? action_rdata : output_rdata;
                        state <= RELEASE_S;
                    end
                end
                RELEASE_S: begin
                    // ack_n low until the host lets go of cs_n
                    if (cfg_valid) begin
                        um2ctrl_ack_n <= 1'b0;
                    end else begin
                        um2ctrl_ack_n <= 1'b1;
                        state         <= IDLE_S;
                    end
                end
                default: begin
                    state <= IDLE_S;
                end
            endcase
        end
    end

endmodule

// ==== pkt_parser.sv ====
`timescale 1ns/100ps

module pkt_parser import pkt_pkg::*, cfg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    // packet input
    input  logic      pktin_data_wr,
    input  beat_t     pktin_data,
    input  logic      pktin_data_valid,
    input  logic      pktin_data_valid_wr,
    output logic      pktin_ready,
    // match request
    output logic      um2me_key_wr,
    output key_t      um2match_key,
    input  logic      um2me_ready,
    // toward the cache
    output beat_t     beat,
    output logic      beat_wr,
    output logic      last,
    output logic      good,
    input  logic      cache_almost_full,
    // register region
    input  logic      cfg_cs,
    input  logic      cfg_rw,
    input  cfg_addr_t cfg_addr,
    input  cfg_data_t cfg_wdata,
    output logic      cfg_ack,
    output cfg_data_t cfg_rdata
);

    localparam int KQ_DEPTH = 8;
    localparam int KQ_AW    = $clog2(KQ_DEPTH);
    localparam int ZERO_W   = KEY_W - BEAT_W - $bits(key_tag_t);

    key_tag_t         key_tag;
    logic             sop;
    logic             kq_push;
    logic             cfg_hit;
    logic             reg0;
    beat_t            kq_mem [KQ_DEPTH];
    logic [KQ_AW-1:0] kq_wr;
    logic [KQ_AW-1:0] kq_rd;
    logic [KQ_AW:0]   kq_cnt;

    // first beats wait here for the match engine
    assign kq_push      = pktin_data_wr && sop;
    assign um2me_key_wr = (kq_cnt != 0) && um2me_ready;
    // tag | 240 zero bits | first beat
    assign um2match_key = {key_tag, {ZERO_W{1'b0}}, kq_mem[kq_rd]};

    assign cfg_hit = cfg_cs && !cfg_ack;
    assign reg0    = (cfg_addr[12:2] == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sop         <= 1'b1;
            beat_wr     <= 1'b0;
            pktin_ready <= 1'b0;
            kq_wr       <= '0;
            kq_rd       <= '0;
            kq_cnt      <= '0;
            key_tag     <= '0;
            cfg_ack     <= 1'b0;
        end else begin
            // next beat opens a packet after a last beat
            if (pktin_data_wr) begin
                sop <= pktin_data_valid_wr;
            end
            beat_wr <= pktin_data_wr;
            // source may still send four beats after ready falls
            pktin_ready <= !cache_almost_full && (kq_cnt < 2);
            if (kq_push) begin
                kq_wr <= kq_wr + 1'b1;
            end
            if (um2me_key_wr) begin
                kq_rd <= kq_rd + 1'b1;
            end
            kq_cnt <= kq_cnt + kq_push - um2me_key_wr;
            cfg_ack <= cfg_hit;
            if (cfg_hit && !cfg_rw && reg0) begin
                key_tag <= cfg_wdata[15:0];
            end
        end
    end

    // data path, one stage toward the cache
    always_ff @(posedge clk) begin
        beat <= pktin_data;
        last <= pktin_data_valid_wr;
        good <= pktin_data_valid;
        if (kq_push) begin
            kq_mem[kq_wr] <= pktin_data;
        end
        if (cfg_hit) begin
            cfg_rdata <= reg0 ? cfg_data_t'(key_tag) : '0;
        end
    end

endmodule

// ==== pkt_cache.sv ====
`timescale 1ns/100ps

module pkt_cache import pkt_pkg::*; #(
    parameter int CACHE_DEPTH = 64
) (
    input  logic  clk,
    input  logic  rst_n,
    // write side
    input  beat_t beat,
    input  logic  beat_wr,
    input  logic  last,
    input  logic  good,
    output logic  almost_full,
    // read side
    input  logic  rd_en,
    output beat_t rd_beat,
    output logic  rd_last,
    output logic  rd_good,
    output logic  empty
);

    localparam int AW = $clog2(CACHE_DEPTH);

    beat_t                  beat_mem [CACHE_DEPTH];
    logic                   last_mem [CACHE_DEPTH];
    logic [CACHE_DEPTH-1:0] good_mem;
    logic [AW:0]            wr_ptr;
    logic [AW:0]            rd_ptr;
    // start of the packet being written
    logic [AW:0]            commit_ptr;
    logic [AW:0]            used;

    assign used        = wr_ptr - rd_ptr;
    assign almost_full = used > (CACHE_DEPTH - 8);
    // only whole packets are visible to the reader
    assign empty       = (rd_ptr == commit_ptr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            commit_ptr <= '0;
        end else begin
            if (beat_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (last) begin
                    commit_ptr <= wr_ptr + 1'b1;
                end
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_wr) begin
            beat_mem[wr_ptr[AW-1:0]] <= beat;
            last_mem[wr_ptr[AW-1:0]] <= last;
            good_mem[wr_ptr[AW-1:0]] <= good;
            // good is only known at the end, copy it to the first beat too
            if (last) begin
                good_mem[commit_ptr[AW-1:0]] <= good;
            end
        end
        // registered read
        if (rd_en) begin
            rd_beat <= beat_mem[rd_ptr[AW-1:0]];
            rd_last <= last_mem[rd_ptr[AW-1:0]];
            rd_good <= good_mem[rd_ptr[AW-1:0]];
        end
    end

endmodule

// ==== action_engine.sv ====
`timescale 1ns/100ps

module action_engine import pkt_pkg::*, cfg_pkg::*; #(
    parameter int RULE_DEPTH = 16,
    parameter int ID_DEPTH   = 8
) (
    input  logic      clk,
    input  logic      rst_n,
    // match reply
    input  logic      me2um_id_wr,
    input  rule_id_t  match2um_id,
    output logic      um2match_gme_alful,
    // cache read
    output logic      rd_en,
    input  beat_t     rd_beat,
    input  logic      rd_last,
    input  logic      rd_good,
    input  logic      empty,
    // toward the output engine
    output beat_t     beat,
    output logic      beat_wr,
    output logic      last,
    input  logic      stall,
    // register region
    input  logic      cfg_cs,
    input  logic      cfg_rw,
    input  cfg_addr_t cfg_addr,
    input  cfg_data_t cfg_wdata,
    output logic      cfg_ack,
    output cfg_data_t cfg_rdata
);

    localparam int RULE_AW = $clog2(RULE_DEPTH);
    localparam int ID_AW   = $clog2(ID_DEPTH);

    typedef enum logic {
        IDLE_A,
        XFER_A
    } act_state_t;

    act_state_t         state;
    rule_id_t           id_mem [ID_DEPTH];
    logic [ID_AW-1:0]   id_wr;
    logic [ID_AW-1:0]   id_rd;
    logic [ID_AW:0]     id_cnt;
    logic               id_push;
    logic               id_pop;
    cfg_data_t          rule_tab [RULE_DEPTH];
    logic [RULE_AW-1:0] cfg_idx;
    logic               cfg_hit;
    logic               rule_fwd;
    logic               head;
    logic               pass_r;
    logic               pass;
    logic               in_flight;
    logic               take;

    // ********************************************************************
    // index queue
    // ********************************************************************
    assign id_push            = me2um_id_wr && (id_cnt != ID_DEPTH);
    // bus access goes first, a packet waits for it
    assign id_pop             = (state == IDLE_A) && (id_cnt != 0) && !cfg_cs;
    assign um2match_gme_alful = id_cnt >= (ID_DEPTH - 2);

    assign cfg_idx = cfg_addr[RULE_AW+1:2];
    assign cfg_hit = cfg_cs && !cfg_ack && (state == IDLE_A);

    // ********************************************************************
    // packet drain
    // ********************************************************************
    // good flag rides on the first beat out of the cache
    assign pass    = head ? (rule_fwd && rd_good) : pass_r;
    // dropped beats leave at once, forwarded ones wait for the stall
    assign take    = in_flight && (!pass || !stall);
    assign rd_en   = (state == XFER_A) && !empty && (!in_flight || (take && !rd_last));
    assign beat    = rd_beat;
    assign last    = rd_last;
    assign beat_wr = in_flight && pass && !stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE_A;
            id_wr     <= '0;
            id_rd     <= '0;
            id_cnt    <= '0;
            head      <= 1'b1;
            pass_r    <= 1'b0;
            rule_fwd  <= 1'b0;
            in_flight <= 1'b0;
            cfg_ack   <= 1'b0;
            // all rules drop after reset
            for (int i = 0; i < RULE_DEPTH; i++) begin
                rule_tab[i] <= '0;
            end
        end else begin
            if (id_push) begin
                id_wr <= id_wr + 1'b1;
            end
            if (id_pop) begin
                id_rd    <= id_rd + 1'b1;
                rule_fwd <= rule_tab[id_mem[id_rd][RULE_AW-1:0]][0];
                state    <= XFER_A;
            end
            id_cnt    <= id_cnt + id_push - id_pop;
            in_flight <= rd_en || (in_flight && !take);
            if (take) begin
                head   <= 1'b0;
                pass_r <= pass;
                if (rd_last) begin
                    head  <= 1'b1;
                    state <= IDLE_A;
                end
            end
            cfg_ack <= cfg_hit;
            if (cfg_hit && !cfg_rw) begin
                rule_tab[cfg_idx] <= cfg_wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (id_push) begin
            id_mem[id_wr] <= match2um_id;
        end
        if (cfg_hit) begin
            cfg_rdata <= rule_tab[cfg_idx];
        end
    end

endmodule

// ==== output_engine.sv ====
`timescale 1ns/100ps

module output_engine import pkt_pkg::*, cfg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    // from the action engine
    input  beat_t     beat,
    input  logic      beat_wr,
    input  logic      last,
    output logic      stall,
    // packet output
    output logic      pktout_data_wr,
    output beat_t     pktout_data,
    output logic      pktout_data_valid,
    output logic      pktout_data_valid_wr,
    input  logic      pktout_ready,
    // register region
    input  logic      cfg_cs,
    input  logic      cfg_rw,
    input  cfg_addr_t cfg_addr,
    input  cfg_data_t cfg_wdata,
    output logic      cfg_ack,
    output cfg_data_t cfg_rdata
);

    logic      full;
    logic      last_r;
    logic      cfg_hit;
    cfg_data_t pkt_cnt;

    // register holds while the port pushes back
    assign stall                = full && !pktout_ready;
    assign pktout_data_wr       = full && pktout_ready;
    assign pktout_data_valid_wr = pktout_data_wr && last_r;
    assign pktout_data_valid    = last_r;

    assign cfg_hit = cfg_cs && !cfg_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full    <= 1'b0;
            pkt_cnt <= '0;
            cfg_ack <= 1'b0;
        end else begin
            if (beat_wr && !stall) begin
                full <= 1'b1;
            end else if (pktout_ready) begin
                full <= 1'b0;
            end
            // any write clears the counter
            if (cfg_hit && !cfg_rw) begin
                pkt_cnt <= '0;
            end else if (pktout_data_valid_wr) begin
                pkt_cnt <= pkt_cnt + 1'b1;
            end
            cfg_ack <= cfg_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_wr && !stall) begin
            pktout_data <= beat;
            last_r      <= last;
        end
        if (cfg_hit) begin
            cfg_rdata <= (cfg_addr[12:2] == '0) ? pkt_cnt : '0;
        end
    end

endmodule

// ==== um.sv ====
`timescale 1ns/100ps

module um import pkt_pkg::*, cfg_pkg::*; #(
    parameter int CACHE_DEPTH = 64,
    parameter int RULE_DEPTH  = 16,
    parameter int ID_DEPTH    = 8
) (
    input  logic      clk,
    input  logic      rst_n,
    // packet input
    input  logic      pktin_data_wr,
    input  beat_t     pktin_data,
    input  logic      pktin_data_valid,
    input  logic      pktin_data_valid_wr,
    output logic      pktin_ready,
    // packet output
    output logic      pktout_data_wr,
    output beat_t     pktout_data,
    output logic      pktout_data_valid,
    output logic      pktout_data_valid_wr,
    input  logic      pktout_ready,
    // match engine
    output logic      um2me_key_wr,
    output key_t      um2match_key,
    input  logic      um2me_ready,
    input  logic      me2um_id_wr,
    input  rule_id_t  match2um_id,
    output logic      um2match_gme_alful,
    // local bus
    input  logic      ctrl2um_cs_n,
    input  logic      ctrl_cmd,
    input  cfg_addr_t ctrl_addr,
    input  cfg_data_t ctrl_datain,
    output logic      um2ctrl_ack_n,
    output cfg_data_t ctrl_dataout
);

    // shared region bus
    logic      cfg_rw;
    cfg_addr_t cfg_addr;
    cfg_data_t cfg_wdata;
    logic      parser_cs;
    logic      parser_ack;
    cfg_data_t parser_rdata;
    logic      action_cs;
    logic      action_ack;
    cfg_data_t action_rdata;
    logic      output_cs;
    logic      output_ack;
    cfg_data_t output_rdata;

    // parser to cache
    beat_t     p_beat;
    logic      p_beat_wr;
    logic      p_last;
    logic      p_good;
    logic      cache_almost_full;

    // cache to action engine
    logic      rd_en;
    beat_t     rd_beat;
    logic      rd_last;
    logic      rd_good;
    logic      cache_empty;

    // action engine to output engine
    beat_t     a_beat;
    logic      a_beat_wr;
    logic      a_last;
    logic      stall;

    cfg_dispatch u_cfg_dispatch (.*);

    pkt_parser u_pkt_parser (
        .*,
        .beat      (p_beat),
        .beat_wr   (p_beat_wr),
        .last      (p_last),
        .good      (p_good),
        .cfg_cs    (parser_cs),
        .cfg_ack   (parser_ack),
        .cfg_rdata (parser_rdata)
    );

    pkt_cache #(
        .CACHE_DEPTH (CACHE_DEPTH)
    ) u_pkt_cache (
        .*,
        .beat        (p_beat),
        .beat_wr     (p_beat_wr),
        .last        (p_last),
        .good        (p_good),
        .almost_full (cache_almost_full),
        .empty       (cache_empty)
    );

    action_engine #(
        .RULE_DEPTH (RULE_DEPTH),
        .ID_DEPTH   (ID_DEPTH)
    ) u_action_engine (
        .*,
        .empty     (cache_empty),
        .beat      (a_beat),
        .beat_wr   (a_beat_wr),
        .last      (a_last),
        .cfg_cs    (action_cs),
        .cfg_ack   (action_ack),
        .cfg_rdata (action_rdata)
    );

    output_engine u_output_engine (
        .*,
        .beat      (a_beat),
        .beat_wr   (a_beat_wr),
        .last      (a_last),
        .cfg_cs    (output_cs),
        .cfg_ack   (output_ack),
        .cfg_rdata (output_rdata)
    );

endmodule

// ==== tb_um.sv ====
`timescale 1ns/100ps

module tb_um import pkt_pkg::*, cfg_pkg::*; ();

    // wait limits, in clock cycles
    localparam int READY_LIMIT = 2000;
    localparam int BUS_LIMIT   = 200;
    localparam int REL_LIMIT   = 8;
    localparam int DRAIN_LIMIT = 20000;

    localparam cfg_addr_t TAG_ADDR = {16'h0, REGION_PARSER, 13'h0};
    localparam cfg_addr_t CNT_ADDR = {16'h0, REGION_OUTPUT, 13'h0};

    logic      clk;
    logic      rst_n;
    logic      pktin_data_wr;
    beat_t     pktin_data;
    logic      pktin_data_valid;
    logic      pktin_data_valid_wr;
    logic      pktin_ready;
    logic      pktout_data_wr;
    beat_t     pktout_data;
    logic      pktout_data_valid;
    logic      pktout_data_valid_wr;
    logic      pktout_ready;
    logic      um2me_key_wr;
    key_t      um2match_key;
    logic      um2me_ready;
    logic      me2um_id_wr;
    rule_id_t  match2um_id;
    logic      um2match_gme_alful;
    logic      ctrl2um_cs_n;
    logic      ctrl_cmd;
    cfg_addr_t ctrl_addr;
    cfg_data_t ctrl_datain;
    logic      um2ctrl_ack_n;
    cfg_data_t ctrl_dataout;

    int          errors;
    int          exp_pkts;
    int          id_delay;
    logic        bp_on;
    logic [15:0] lfsr_state;
    key_tag_t    tag_model;
    cfg_data_t   rule_model [16];

    // scoreboard queues
    beat_t       exp_beat_q [$];
    logic        exp_last_q [$];
    key_t        key_q [$];
    logic [3:0]  id_q [$];

    um #(
        .CACHE_DEPTH (64),
        .RULE_DEPTH  (16),
        .ID_DEPTH    (8)
    ) dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // **********************************************************************
    // random source and reporting
    // **********************************************************************
    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one step per bit
    function logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function beat_t rand_beat();
        beat_t b;
        for (int k = 0; k < BEAT_W / 32; k++) begin
            b[k*32 +: 32] = take_bits(32);
        end
        return b;
    endfunction

    function cfg_addr_t rule_addr(input int idx);
        return {16'h0, REGION_ACTION, 13'(idx * 4)};
    endfunction

    task report_value(input string name, input logic [511:0] got, input logic [511:0] exp);
        errors++;
        $display("** Error: %s got %0h expected %0h at %0t", name, got, exp, $time);
    endtask

    task report_text(input string msg);
        errors++;
        $display("%s at %0t", msg, $time);
    endtask

    task abort_run(input string why);
        errors++;
        $display("%s at %0t", why, $time);
        $display("errors: %0d", errors);
        $display("sim failed");
        $finish;
    endtask

    // **********************************************************************
    // local bus
    // **********************************************************************
    task bus_access(input logic rd, input cfg_addr_t addr, input cfg_data_t wdata,
                    output cfg_data_t rdata);
        int cnt;
        @(posedge clk);
        ctrl_cmd     <= rd;
        ctrl_addr    <= addr;
        ctrl_datain  <= wdata;
        ctrl2um_cs_n <= 1'b0;
        cnt = 0;
        @(posedge clk);
        // hold the command until ack_n falls
        while (um2ctrl_ack_n) begin
            cnt++;
            if (cnt > BUS_LIMIT) begin
                abort_run("local bus access never acknowledged");
            end
            @(posedge clk);
        end
        rdata = ctrl_dataout;
        ctrl2um_cs_n <= 1'b1;
        cnt = 0;
        @(posedge clk);
        while (!um2ctrl_ack_n) begin
            cnt++;
            if (cnt > REL_LIMIT) begin
                abort_run("ack_n stayed low after cs_n was released");
            end
            @(posedge clk);
        end
    endtask

    task bus_write(input cfg_addr_t addr, input cfg_data_t data);
        cfg_data_t unused;
        bus_access(1'b0, addr, data, unused);
    endtask

    task check_read(input cfg_addr_t addr, input cfg_data_t exp, input string name);
        cfg_data_t got;
        bus_access(1'b1, addr, '0, got);
        assert (got == exp) else report_value(name, got, exp);
    endtask

    // rule bit 0 either on a fixed pattern or random
    task program_rules(input logic random_bit0);
        cfg_data_t w;
        for (int i = 0; i < 16; i++) begin
            w[31:1] = take_bits(31);
            w[0]    = random_bit0 ? take_bits(1) : ((i % 3) != 0);
            rule_model[i] = w;
            bus_write(rule_addr(i), w);
        end
        for (int i = 0; i < 16; i++) begin
            check_read(rule_addr(i), rule_model[i], $sformatf("rule_tab[%0d]", i));
        end
    endtask

    task set_tag(input cfg_data_t data);
        tag_model = data[15:0];
        bus_write(TAG_ADDR, data);
        // only 16 bits stored
        check_read(TAG_ADDR, {16'h0, data[15:0]}, "key_tag");
    endtask

    // **********************************************************************
    // packet input
    // **********************************************************************
    task wait_in_ready();
        int cnt;
        cnt = 0;
        @(posedge clk);
        while (!pktin_ready) begin
            pktin_data_wr       <= 1'b0;
            pktin_data_valid_wr <= 1'b0;
            pktin_data_valid    <= 1'b0;
            cnt++;
            if (cnt > READY_LIMIT) begin
                abort_run("pktin_ready stayed low, input blocked");
            end
            @(posedge clk);
        end
    endtask

    task send_packet(input int nbeats, input logic good_pkt);
        beat_t b;
        logic  fwd;
        fwd = 1'b0;
        for (int i = 0; i < nbeats; i++) begin
            b = rand_beat();
            if (i == 0) begin
                // rule index is the low key bits, i.e. the low beat bits
                fwd = rule_model[b[3:0]][0] && good_pkt;
                key_q.push_back({tag_model, 240'h0, b});
                if (fwd) begin
                    exp_pkts++;
                end
            end
            wait_in_ready();
            pktin_data_wr       <= 1'b1;
            pktin_data          <= b;
            pktin_data_valid_wr <= (i == nbeats - 1);
            pktin_data_valid    <= (i == nbeats - 1) ? good_pkt : 1'b0;
            if (fwd) begin
                exp_beat_q.push_back(b);
                exp_last_q.push_back(i == nbeats - 1);
            end
        end
    endtask

    task run_traffic(input int npkts);
        int gap;
        for (int p = 0; p < npkts; p++) begin
            // 1 to 4 beats, one in four packets bad
            send_packet(1 + take_bits(2), take_bits(2) != 0);
            gap = take_bits(2);
            if (gap != 0) begin
                @(posedge clk);
                pktin_data_wr       <= 1'b0;
                pktin_data_valid_wr <= 1'b0;
                pktin_data_valid    <= 1'b0;
                repeat (gap - 1) @(posedge clk);
            end
        end
        @(posedge clk);
        pktin_data_wr       <= 1'b0;
        pktin_data_valid_wr <= 1'b0;
        pktin_data_valid    <= 1'b0;
    endtask

    task drain();
        int cnt;
        cnt = 0;
        while (exp_beat_q.size() != 0 || key_q.size() != 0 || id_q.size() != 0) begin
            cnt++;
            if (cnt > DRAIN_LIMIT) begin
                abort_run("expected packets never left the DUT");
            end
            @(posedge clk);
        end
        // window for stray beats of dropped packets
        repeat (40) @(posedge clk);
        // all indices used up and the input open again
        assert (um2match_gme_alful == 1'b0)
            else report_value("um2match_gme_alful", um2match_gme_alful, 1'b0);
        assert (pktin_ready == 1'b1)
            else report_value("pktin_ready", pktin_ready, 1'b1);
    endtask

    // **********************************************************************
    // match engine model and port pressure
    // **********************************************************************
    always @(posedge clk) begin : match_model
        if (!rst_n) begin
            me2um_id_wr <= 1'b0;
            id_delay = 0;
        end else begin
            me2um_id_wr <= 1'b0;
            if (um2me_key_wr) begin
                id_q.push_back(um2match_key[3:0]);
            end
            // in order, random delay, held off while the id queue is nearly full
            if (id_delay != 0) begin
                id_delay--;
            end else if (id_q.size() != 0 && !um2match_gme_alful) begin
                me2um_id_wr <= 1'b1;
                match2um_id <= rule_id_t'(id_q.pop_front());
                id_delay = take_bits(3);
            end
        end
    end

    always @(posedge clk) begin : port_pressure
        if (!rst_n || !bp_on) begin
            pktout_ready <= 1'b1;
            um2me_ready  <= 1'b1;
        end else begin
            pktout_ready <= take_bits(2) != 0;
            um2me_ready  <= take_bits(3) != 0;
        end
    end

    // **********************************************************************
    // checkers
    // **********************************************************************
    always @(posedge clk) begin : key_check
        key_t exp_key;
        if (rst_n && um2me_key_wr) begin
            if (key_q.size() == 0) begin
                report_text("key request with no packet outstanding");
            end else begin
                exp_key = key_q.pop_front();
                assert (um2match_key == exp_key)
                    else report_value("um2match_key", um2match_key, exp_key);
            end
        end
    end

    always @(posedge clk) begin : out_check
        beat_t exp_b;
        logic  exp_l;
        if (rst_n) begin
            assert (!(pktout_data_wr && !pktout_ready))
                else report_text("pktout_data_wr high while pktout_ready was low");
            if (pktout_data_wr) begin
                if (exp_beat_q.size() == 0) begin
                    report_text("output beat seen with no packet expected");
                end else begin
                    exp_b = exp_beat_q.pop_front();
                    exp_l = exp_last_q.pop_front();
                    assert (pktout_data == exp_b)
                        else report_value("pktout_data", pktout_data, exp_b);
                    assert (pktout_data_valid_wr == exp_l)
                        else report_value("pktout_data_valid_wr", pktout_data_valid_wr, exp_l);
                    if (exp_l) begin
                        assert (pktout_data_valid == 1'b1)
                            else report_value("pktout_data_valid", pktout_data_valid, 1'b1);
                    end
                end
            end
        end
    end

    // **********************************************************************
    // main sequence
    // **********************************************************************
    initial begin
        errors              = 0;
        exp_pkts            = 0;
        id_delay            = 0;
        bp_on               = 1'b0;
        lfsr_state          = 16'd80;
        tag_model           = '0;
        rst_n               = 1'b0;
        pktin_data_wr       = 1'b0;
        pktin_data          = '0;
        pktin_data_valid    = 1'b0;
        pktin_data_valid_wr = 1'b0;
        pktout_ready        = 1'b1;
        um2me_ready         = 1'b1;
        me2um_id_wr         = 1'b0;
        match2um_id         = '0;
        ctrl2um_cs_n        = 1'b1;
        ctrl_cmd            = 1'b0;
        ctrl_addr           = '0;
        ctrl_datain         = '0;
        for (int i = 0; i < 16; i++) begin
            rule_model[i] = '0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // registers, upper tag bits must be dropped
        set_tag(32'hDEAD_A5C3);
        program_rules(1'b0);

        // unmapped regions answer zero
        check_read({16'h0, 3'd0, 13'h010}, '0, "unmapped rdata");
        check_read({16'h0, 3'd7, 13'h004}, '0, "unmapped rdata");
        bus_write({16'h0, 3'd0, 13'h020}, 32'h1234_5678);
        check_read(CNT_ADDR, '0, "pkt_cnt");

        // traffic, free-running output
        run_traffic(12);
        drain();
        check_read(CNT_ADDR, exp_pkts, "pkt_cnt");
        bus_write(CNT_ADDR, 32'hFFFF_FFFF);
        exp_pkts = 0;
        check_read(CNT_ADDR, '0, "pkt_cnt");

        // new tag and rules, then back-pressure on both ports
        set_tag(take_bits(32));
        program_rules(1'b1);
        bp_on <= 1'b1;
        run_traffic(30);
        drain();
        bp_on <= 1'b0;
        check_read(CNT_ADDR, exp_pkts, "pkt_cnt");

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
pkt_pkg.sv
cfg_pkg.sv
cfg_dispatch.sv
pkt_parser.sv
pkt_cache.sv
action_engine.sv
output_engine.sv
um.sv
tb_um.sv
